/* Bender.yml */
package:
  name: rv_core

sources:
  - src/rv_pkg.sv
  - src/mem_req_if.sv
  - src/rv_regfile.sv
  - src/rv_decode.sv
  - src/rv_alu.sv
  - src/rv_mem_port.sv
  - src/rv_control.sv
  - src/rv_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/tb_rv_top.sv

/* list.f */
src/rv_pkg.sv
src/mem_req_if.sv
src/rv_regfile.sv
src/rv_decode.sv
src/rv_alu.sv
src/rv_mem_port.sv
src/rv_control.sv
src/rv_top.sv
sim/tb_clock.sv
sim/tb_rv_top.sv

/* sim/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
	input wire i_reset_request,
	output logic o_clock,
	output logic o_reset
);
	// 10 ns period
	initial begin
		o_clock = 1'b0;
		forever begin
			#5 o_clock = ~o_clock;
		end
	end

	// reset spans three rising edges and changes on the falling edge
	initial begin
		o_reset = 1'b1;
		forever begin
			repeat (3) @(posedge o_clock);
			@(negedge o_clock);
			o_reset = 1'b0;
			@(posedge i_reset_request);
			@(negedge o_clock);
			o_reset = 1'b1;
		end
	end
endmodule

`default_nettype wire

/* sim/tb_rv_top.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_top import rv_pkg::*; ();
	localparam int NUM_ROWS = 6;
	localparam int MAX_INSTR = 16;
	localparam int MEM_WORDS = 256;
	localparam word_t DATA_ADDR = 32'h0000_0200;
	localparam word_t RESULT_ADDR = 32'h0000_0300;
	localparam word_t NOP = 32'h0000_0013;
	// rows x instructions x transfers x cycles per transfer x period
	localparam int WATCHDOG_NS = NUM_ROWS * MAX_INSTR * 5 * 4 * 10;

	logic clock;
	logic reset;
	logic reset_request = 1'b0;
	logic rw;
	logic request;
	logic ready = 1'b0;
	word_t address;
	word_t rdata = 32'd0;
	word_t wdata;
	word_t pc;
	logic error;

	word_t mem_words [MEM_WORDS];
	word_t code_tab [NUM_ROWS][MAX_INSTR];
	word_t data_tab [NUM_ROWS];
	word_t expect_tab [NUM_ROWS];
	logic halt_tab [NUM_ROWS];
	int fill_row;
	int fill_pos;

	word_t lfsr = 32'hc48f;
	logic busy = 1'b0;
	int wait_left = 0;
	logic result_seen = 1'b0;
	word_t result_value = 32'd0;
	int error_count = 0;

	tb_clock i_clock_gen (
		.i_reset_request(reset_request),
		.o_clock(clock),
		.o_reset(reset)
	);

	rv_top i_dut (
		.i_clock(clock),
		.i_reset(reset),
		.o_rw(rw),
		.o_request(request),
		.i_ready(ready),
		.o_address(address),
		.i_data(rdata),
		.o_data(wdata),
		.o_pc(pc),
		.o_error(error)
	);

	// Fibonacci taps 32, 22, 2, 1
	function automatic word_t lfsr_step(input word_t state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// instruction encoders for the RV32I formats
	function automatic word_t itype(input opcode_t opc, input logic [2:0] f3,
		input reg_idx_t rd, input reg_idx_t rs1, input int imm);
		return {imm[11:0], rs1, f3, rd, opc};
	endfunction

	function automatic word_t rtype(input logic [6:0] f7, input logic [2:0] f3,
		input reg_idx_t rd, input reg_idx_t rs1, input reg_idx_t rs2);
		return {f7, rs2, rs1, f3, rd, OPC_OP};
	endfunction

	function automatic word_t stype(input logic [2:0] f3, input reg_idx_t rs2,
		input reg_idx_t rs1, input int imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
	endfunction

	function automatic word_t btype(input logic [2:0] f3, input reg_idx_t rs1,
		input reg_idx_t rs2, input int imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	function automatic word_t utype(input opcode_t opc, input reg_idx_t rd, input int imm);
		return {imm[19:0], rd, opc};
	endfunction

	function automatic word_t jtype(input reg_idx_t rd, input int imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
	endfunction

	task automatic stop_with_failure();
		$display("=== FAIL ===");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			error_count++;
			$display("Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			error_count++;
			$display("Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
			stop_with_failure();
		end
	endtask

	task automatic start_row(input int row, input word_t data, input word_t expected,
		input logic halts);
		fill_row = row;
		fill_pos = 0;
		data_tab[row] = data;
		expect_tab[row] = expected;
		halt_tab[row] = halts;
	endtask

	task automatic append_instr(input word_t instr);
		code_tab[fill_row][fill_pos] = instr;
		fill_pos++;
	endtask

	task automatic build_table();
		for (int r = 0; r < NUM_ROWS; r++) begin
			for (int k = 0; k < MAX_INSTR; k++) begin
				code_tab[r][k] = NOP;
			end
		end
		// arithmetic, logic, shifts and compares
		start_row(0, 32'd0, 32'h0000_05a0, 1'b0);
		append_instr(itype(OPC_OP_IMM, 3'b000, 1, 0, -20));
		append_instr(itype(OPC_OP_IMM, 3'b101, 3, 1, 'h402));
		append_instr(itype(OPC_OP_IMM, 3'b000, 4, 0, 7));
		append_instr(rtype(7'b0000000, 3'b011, 5, 4, 1));
		append_instr(rtype(7'b0000000, 3'b010, 6, 1, 4));
		append_instr(rtype(7'b0100000, 3'b000, 7, 4, 3));
		append_instr(rtype(7'b0000000, 3'b001, 8, 7, 6));
		append_instr(rtype(7'b0000000, 3'b100, 9, 8, 3));
		append_instr(itype(OPC_OP_IMM, 3'b101, 10, 9, 4));
		append_instr(itype(OPC_OP_IMM, 3'b111, 11, 10, 'h5a5));
		append_instr(rtype(7'b0000000, 3'b000, 12, 11, 3));
		append_instr(rtype(7'b0000000, 3'b000, 12, 12, 5));
		append_instr(stype(3'b010, 12, 0, 'h300));
		// blt taken, bltu not taken, jal and jalr with links 28 and 40
		start_row(1, 32'd0, 32'h0000_004a, 1'b0);
		append_instr(itype(OPC_OP_IMM, 3'b000, 1, 0, 5));
		append_instr(itype(OPC_OP_IMM, 3'b000, 2, 0, -3));
		append_instr(btype(3'b100, 2, 1, 8));
		append_instr(itype(OPC_OP_IMM, 3'b000, 1, 0, 99));
		append_instr(btype(3'b110, 2, 1, 8));
		append_instr(itype(OPC_OP_IMM, 3'b000, 3, 0, 1));
		append_instr(jtype(4, 8));
		append_instr(itype(OPC_OP_IMM, 3'b000, 3, 0, 77));
		// odd target whose bit 0 gets cleared
		append_instr(itype(OPC_OP_IMM, 3'b000, 5, 0, 45));
		append_instr(itype(OPC_JALR, 3'b000, 6, 5, 0));
		append_instr(itype(OPC_OP_IMM, 3'b000, 3, 3, 64));
		append_instr(rtype(7'b0000000, 3'b000, 7, 4, 6));
		append_instr(rtype(7'b0000000, 3'b000, 7, 7, 3));
		append_instr(rtype(7'b0000000, 3'b000, 7, 7, 1));
		append_instr(stype(3'b010, 7, 0, 'h300));
		// lb ffffff85, lbu 7e, lh ffff80f1, lhu 7e85
		start_row(2, 32'h80f1_7e85, 32'h0000_fe77, 1'b0);
		append_instr(itype(OPC_LOAD, 3'b000, 1, 0, 'h200));
		append_instr(itype(OPC_LOAD, 3'b100, 2, 0, 'h201));
		append_instr(itype(OPC_LOAD, 3'b001, 3, 0, 'h202));
		append_instr(itype(OPC_LOAD, 3'b101, 4, 0, 'h200));
		append_instr(rtype(7'b0000000, 3'b100, 6, 1, 3));
		append_instr(rtype(7'b0000000, 3'b000, 6, 6, 2));
		append_instr(rtype(7'b0000000, 3'b000, 6, 6, 4));
		append_instr(stype(3'b010, 6, 0, 'h300));
		// sb ab into lane 1, sh 5678 into the upper half
		start_row(3, 32'h1122_3344, 32'h5678_ab44, 1'b0);
		append_instr(itype(OPC_OP_IMM, 3'b000, 1, 0, -85));
		append_instr(stype(3'b000, 1, 0, 'h201));
		append_instr(utype(OPC_LUI, 2, 'h12345));
		append_instr(itype(OPC_OP_IMM, 3'b000, 2, 2, 'h678));
		append_instr(stype(3'b001, 2, 0, 'h202));
		append_instr(itype(OPC_LOAD, 3'b010, 3, 0, 'h200));
		append_instr(stype(3'b010, 3, 0, 'h300));
		// sp straight out of reset
		start_row(4, 32'd0, 32'h0001_0400, 1'b0);
		append_instr(stype(3'b010, 2, 0, 'h300));
		// all-zero word has no valid opcode
		start_row(5, 32'd0, 32'd0, 1'b1);
		append_instr(itype(OPC_OP_IMM, 3'b000, 1, 0, 1));
		append_instr(32'h0000_0000);
		// a halted core never reaches this store
		append_instr(stype(3'b010, 1, 0, 'h300));
	endtask

	// memory model answering on the falling edge
	always @(negedge clock) begin
		if (reset || !request) begin
			ready <= 1'b0;
			busy = 1'b0;
		end else begin
			if (!busy) begin
				busy = 1'b1;
				lfsr = lfsr_step(lfsr);
				wait_left = int'(lfsr[0]);
				lfsr = lfsr_step(lfsr);
				wait_left = wait_left * 2 + int'(lfsr[0]);
			end
			if (wait_left > 0) begin
				ready <= 1'b0;
				wait_left--;
			end else if (address[31:10] != 22'd0) begin
				$display("Error at %0t ns: access to %h is outside the memory model",
					$time, address);
				stop_with_failure();
			end else begin
				ready <= 1'b1;
				busy = 1'b0;
				rdata <= mem_words[address[9:2]];
				if (rw) begin
					mem_words[address[9:2]] = wdata;
					if (address[31:2] == RESULT_ADDR[31:2]) begin
						result_seen = 1'b1;
						result_value = wdata;
					end
				end
			end
		end
	end

	task automatic restart_core(input int row);
		reset_request = 1'b1;
		wait (reset === 1'b1);
		reset_request = 1'b0;
		result_seen = 1'b0;
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem_words[a] = 32'h5a00_0000 | word_t'(a * 4);
		end
		for (int k = 0; k < MAX_INSTR; k++) begin
			mem_words[k] = code_tab[row][k];
		end
		mem_words[DATA_ADDR[9:2]] = data_tab[row];
		wait (reset === 1'b0);
		check_flag("o_request", request, 1'b0);
		check_flag("o_rw", rw, 1'b0);
		check_flag("o_error", error, 1'b0);
		// first fetch goes out one cycle after reset
		@(negedge clock);
		check_flag("o_request", request, 1'b1);
		check_word("o_address", address, 32'h0000_0000);
	endtask

	task automatic check_result(input int row);
		wait (result_seen === 1'b1);
		check_word("o_data", result_value, expect_tab[row]);
		check_flag("o_error", error, 1'b0);
	endtask

	task automatic check_halt();
		wait (error === 1'b1);
		@(negedge clock);
		check_word("o_pc", pc, 32'h0000_0004);
		check_flag("result_seen", result_seen, 1'b0);
		repeat (16) begin
			@(negedge clock);
			check_flag("o_request", request, 1'b0);
			check_flag("o_error", error, 1'b1);
		end
		check_flag("result_seen", result_seen, 1'b0);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("core stalled: no result after %0d ns", WATCHDOG_NS);
		stop_with_failure();
	end

	initial begin
		build_table();
		for (int row = 0; row < NUM_ROWS; row++) begin
			restart_core(row);
			if (halt_tab[row]) begin
				check_halt();
			end else begin
				check_result(row);
			end
		end
		if (error_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end
endmodule

`default_nettype wire

/* src/mem_req_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface mem_req_if import rv_pkg::*; ();
	logic valid;
	logic write;
	mem_size_t size;
	logic unsigned_load;
	word_t address;
	word_t wdata;
	word_t rdata;
	logic done;

	modport ctrl (output valid, write, size, unsigned_load, address, wdata,
		input rdata, done);
	modport port (input valid, write, size, unsigned_load, address, wdata,
		output rdata, done);
endinterface

`default_nettype wire

/* src/rv_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_alu import rv_pkg::*; (
	input wire alu_op_t i_op,
	input wire word_t i_a,
	input wire word_t i_b,
	input wire [2:0] i_funct3,
	output word_t o_result,
	output logic o_branch_taken
);
	logic [4:0] shamt;

	assign shamt = i_b[4:0];

	always_comb begin
		case (i_op)
			ALU_ADD: o_result = i_a + i_b;
			ALU_SUB: o_result = i_a - i_b;
			ALU_SLL: o_result = i_a << shamt;
			ALU_SLT: o_result = {31'd0, $signed(i_a) < $signed(i_b)};
			ALU_SLTU: o_result = {31'd0, i_a < i_b};
			ALU_XOR: o_result = i_a ^ i_b;
			ALU_SRL: o_result = i_a >> shamt;
			ALU_SRA: o_result = $unsigned($signed(i_a) >>> shamt);
			ALU_OR: o_result = i_a | i_b;
			ALU_AND: o_result = i_a & i_b;
			default: o_result = 32'd0;
		endcase
	end

	// funct3 encodings 010 and 011 are not branches
	always_comb begin
		case (i_funct3)
			3'b000: o_branch_taken = (i_a == i_b);
			3'b001: o_branch_taken = (i_a != i_b);
			3'b100: o_branch_taken = ($signed(i_a) < $signed(i_b));
			3'b101: o_branch_taken = ($signed(i_a) >= $signed(i_b));
			3'b110: o_branch_taken = (i_a < i_b);
			3'b111: o_branch_taken = (i_a >= i_b);
			default: o_branch_taken = 1'b0;
		endcase
	end
endmodule

`default_nettype wire

/* src/rv_control.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_control import rv_pkg::*; (
	input wire i_clock,
	input wire i_reset,
	input wire op_class_t i_class,
	input wire reg_idx_t i_rd,
	input wire word_t i_imm,
	input wire alu_op_t i_alu_op,
	input wire [2:0] i_funct3,
	input wire i_alu_use_imm,
	input wire word_t i_alu_result,
	input wire i_branch_taken,
	output alu_op_t o_alu_op,
	output word_t o_alu_a,
	output word_t o_alu_b,
	output word_t o_instruction,
	output logic o_wr_en,
	output reg_idx_t o_wr_idx,
	output word_t o_wr_data,
	input wire word_t i_rs1_data,
	input wire word_t i_rs2_data,
	mem_req_if.ctrl mem,
	output word_t o_pc,
	output logic o_error
);
	ctrl_state_t state;
	word_t pc;
	word_t pc_next;
	word_t instruction;
	word_t next_pc;
	word_t pc_plus4;
	word_t pc_plus_imm;

	assign o_instruction = instruction;
	assign o_pc = pc;
	assign o_error = (state == ST_ERROR);

	// operand select for the ALU
	assign o_alu_op = i_alu_op;
	assign o_alu_a = i_rs1_data;
	assign o_alu_b = i_alu_use_imm ? i_imm : i_rs2_data;

	assign pc_plus4 = pc + 32'd4;
	assign pc_plus_imm = pc + i_imm;

	always_comb begin
		next_pc = pc_plus4;
		case (i_class)
			CLS_JAL: next_pc = pc_plus_imm;
			CLS_JALR: next_pc = i_alu_result & ~32'd1;
			CLS_BRANCH: begin
				if (i_branch_taken) begin
					next_pc = pc_plus_imm;
				end
			end
			default: next_pc = pc_plus4;
		endcase
	end

	// retire already requests the next fetch
	always_comb begin
		mem.valid = 1'b0;
		mem.write = 1'b0;
		mem.size = SIZE_WORD;
		mem.unsigned_load = 1'b0;
		mem.address = pc;
		mem.wdata = i_rs2_data;
		case (state)
			ST_FETCH: mem.valid = 1'b1;
			ST_MEMORY: begin
				mem.valid = 1'b1;
				mem.write = (i_class == CLS_STORE);
				mem.size = mem_size_t'(i_funct3[1:0]);
				mem.unsigned_load = i_funct3[2];
				mem.address = i_alu_result;
			end
			ST_RETIRE: begin
				mem.valid = 1'b1;
				mem.address = pc_next;
			end
			default: mem.valid = 1'b0;
		endcase
	end

	always_comb begin
		o_wr_en = 1'b0;
		o_wr_idx = i_rd;
		o_wr_data = i_alu_result;
		if (state == ST_EXECUTE) begin
			case (i_class)
				CLS_LUI: begin
					o_wr_en = 1'b1;
					o_wr_data = i_imm;
				end
				CLS_AUIPC: begin
					o_wr_en = 1'b1;
					o_wr_data = pc_plus_imm;
				end
				CLS_JAL, CLS_JALR: begin
					o_wr_en = 1'b1;
					o_wr_data = pc_plus4;
				end
				CLS_OP, CLS_OP_IMM: o_wr_en = 1'b1;
				default: o_wr_en = 1'b0;
			endcase
		end else if (state == ST_MEMORY && i_class == CLS_LOAD && mem.done) begin
			o_wr_en = 1'b1;
			o_wr_data = mem.rdata;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_FETCH;
			pc <= RESET_PC;
			pc_next <= RESET_PC;
		end else begin
			case (state)
				ST_FETCH: begin
					if (mem.done) begin
						state <= ST_EXECUTE;
					end
				end
				ST_EXECUTE: begin
					pc_next <= next_pc;
					if (i_class == CLS_ILLEGAL) begin
						state <= ST_ERROR;
					end else if (i_class == CLS_LOAD || i_class == CLS_STORE) begin
						state <= ST_MEMORY;
					end else begin
						state <= ST_RETIRE;
					end
				end
				ST_MEMORY: begin
					if (mem.done) begin
						state <= ST_RETIRE;
					end
				end
				ST_RETIRE: begin
					pc <= pc_next;
					state <= ST_FETCH;
				end
				default: state <= ST_ERROR;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == ST_FETCH && mem.done) begin
			instruction <= mem.rdata;
		end
	end

	// halt is final with no writes and no bus traffic afterwards
	assert property (@(posedge i_clock) disable iff (i_reset)
		(state == ST_ERROR) |=> (state == ST_ERROR && !o_wr_en && !mem.valid));
endmodule

`default_nettype wire

/* src/rv_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_decode import rv_pkg::*; (
	input wire word_t i_instruction,
	output op_class_t o_class,
	output reg_idx_t o_rd,
	output reg_idx_t o_rs1,
	output reg_idx_t o_rs2,
	output word_t o_imm,
	output alu_op_t o_alu_op,
	output logic [2:0] o_funct3,
	output logic o_alu_use_imm
);
	opcode_t opcode;
	word_t imm_b;
	word_t imm_i;
	word_t imm_j;
	word_t imm_s;
	word_t imm_u;

	assign opcode = i_instruction[6:0];
	assign o_rd = i_instruction[11:7];
	assign o_rs1 = i_instruction[19:15];
	assign o_rs2 = i_instruction[24:20];
	assign o_funct3 = i_instruction[14:12];

	// immediate formats
	assign imm_b = {{20{i_instruction[31]}}, i_instruction[7], i_instruction[30:25],
		i_instruction[11:8], 1'b0};
	assign imm_i = {{21{i_instruction[31]}}, i_instruction[30:20]};
	assign imm_j = {{12{i_instruction[31]}}, i_instruction[19:12], i_instruction[20],
		i_instruction[30:21], 1'b0};
	assign imm_s = {{21{i_instruction[31]}}, i_instruction[30:25], i_instruction[11:7]};
	assign imm_u = {i_instruction[31:12], 12'b0};

	always_comb begin
		case (opcode)
			OPC_LUI: o_class = CLS_LUI;
			OPC_AUIPC: o_class = CLS_AUIPC;
			OPC_JAL: o_class = CLS_JAL;
			OPC_JALR: o_class = CLS_JALR;
			OPC_BRANCH: o_class = CLS_BRANCH;
			OPC_LOAD: o_class = CLS_LOAD;
			OPC_STORE: o_class = CLS_STORE;
			OPC_OP_IMM: o_class = CLS_OP_IMM;
			OPC_OP: o_class = CLS_OP;
			default: o_class = CLS_ILLEGAL;
		endcase
	end

	always_comb begin
		case (o_class)
			CLS_LUI, CLS_AUIPC: o_imm = imm_u;
			CLS_JAL: o_imm = imm_j;
			CLS_JALR, CLS_LOAD, CLS_OP_IMM: o_imm = imm_i;
			CLS_BRANCH: o_imm = imm_b;
			CLS_STORE: o_imm = imm_s;
			default: o_imm = 32'd0;
		endcase
	end

	// address generation and jalr use plain add
	always_comb begin
		o_alu_op = ALU_ADD;
		if (o_class == CLS_OP || o_class == CLS_OP_IMM) begin
			case (o_funct3)
				3'b000: o_alu_op = (o_class == CLS_OP && i_instruction[30]) ? ALU_SUB : ALU_ADD;
				3'b001: o_alu_op = ALU_SLL;
				3'b010: o_alu_op = ALU_SLT;
				3'b011: o_alu_op = ALU_SLTU;
				3'b100: o_alu_op = ALU_XOR;
				3'b101: o_alu_op = i_instruction[30] ? ALU_SRA : ALU_SRL;
				3'b110: o_alu_op = ALU_OR;
				default: o_alu_op = ALU_AND;
			endcase
		end
	end

	// branches compare rs1 against rs2
	assign o_alu_use_imm = (o_class != CLS_OP) && (o_class != CLS_BRANCH);
endmodule

`default_nettype wire

/* src/rv_mem_port.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_mem_port import rv_pkg::*; (
	input wire i_clock,
	input wire i_reset,
	mem_req_if.port mem,
	output logic o_rw,
	output logic o_request,
	output word_t o_address,
	input wire word_t i_data,
	output word_t o_data,
	input wire i_ready
);
	logic rmw_read;
	logic wr_pending;
	logic [4:0] lane_shift;
	word_t lane_mask;
	word_t load_shifted;
	word_t store_merged;

	// byte lanes come from the low address bits
	assign lane_shift = {o_address[1:0], 3'b000};
	assign load_shifted = i_data >> lane_shift;

	always_comb begin
		case (mem.size)
			SIZE_BYTE: lane_mask = 32'h0000_00ff << lane_shift;
			SIZE_HALF: lane_mask = 32'h0000_ffff << lane_shift;
			default: lane_mask = 32'hffff_ffff;
		endcase
	end

	assign store_merged = (i_data & ~lane_mask) | ((mem.wdata << lane_shift) & lane_mask);

	always_comb begin
		case (mem.size)
			SIZE_BYTE: mem.rdata = mem.unsigned_load ? {24'd0, load_shifted[7:0]}
				: {{24{load_shifted[7]}}, load_shifted[7:0]};
			SIZE_HALF: mem.rdata = mem.unsigned_load ? {16'd0, load_shifted[15:0]}
				: {{16{load_shifted[15]}}, load_shifted[15:0]};
			default: mem.rdata = i_data;
		endcase
	end

	// the read half of a sub-word store is not a completion
	assign mem.done = o_request && i_ready && !rmw_read;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_request <= 1'b0;
			o_rw <= 1'b0;
			rmw_read <= 1'b0;
			wr_pending <= 1'b0;
		end else if (!o_request) begin
			if (wr_pending) begin
				// write back the merged word
				o_request <= 1'b1;
				o_rw <= 1'b1;
				wr_pending <= 1'b0;
			end else if (mem.valid) begin
				o_request <= 1'b1;
				o_rw <= mem.write && (mem.size == SIZE_WORD);
				rmw_read <= mem.write && (mem.size != SIZE_WORD);
			end
		end else if (i_ready) begin
			o_request <= 1'b0;
			o_rw <= 1'b0;
			if (rmw_read) begin
				rmw_read <= 1'b0;
				wr_pending <= 1'b1;
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (!o_request && !wr_pending && mem.valid) begin
			o_address <= mem.address;
			o_data <= mem.wdata;
		end else if (o_request && i_ready && rmw_read) begin
			o_data <= store_merged;
		end
	end

	// bus fields hold while the slave stalls
	assert property (@(posedge i_clock) disable iff (i_reset)
		(o_request && !i_ready) |=> (o_request && $stable(o_address) && $stable(o_rw)));

	// a request drops after completion
	assert property (@(posedge i_clock) disable iff (i_reset)
		(o_request && i_ready) |=> !o_request);

	// the control side keeps an access open until it completes
	assert property (@(posedge i_clock) disable iff (i_reset)
		(mem.valid && !mem.done) |=> mem.valid);
endmodule

`default_nettype wire

/* src/rv_pkg.sv */
`default_nettype none

package rv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [6:0] opcode_t;

	// base opcodes handled by the core
	localparam opcode_t OPC_LUI = 7'b0110111;
	localparam opcode_t OPC_AUIPC = 7'b0010111;
	localparam opcode_t OPC_JAL = 7'b1101111;
	localparam opcode_t OPC_JALR = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_LOAD = 7'b0000011;
	localparam opcode_t OPC_STORE = 7'b0100011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP = 7'b0110011;

	typedef enum logic [3:0] {
		CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_BRANCH,
		CLS_LOAD, CLS_STORE, CLS_OP_IMM, CLS_OP, CLS_ILLEGAL
	} op_class_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_t;

	// matches funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		SIZE_BYTE = 2'b00,
		SIZE_HALF = 2'b01,
		SIZE_WORD = 2'b10
	} mem_size_t;

	typedef enum logic [2:0] {
		ST_FETCH, ST_EXECUTE, ST_MEMORY, ST_RETIRE, ST_ERROR
	} ctrl_state_t;

	localparam word_t RESET_PC = 32'h0000_0000;
	// initial stack pointer
	localparam word_t RESET_SP = 32'h0001_0400;

endpackage

`default_nettype wire

/* src/rv_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_regfile import rv_pkg::*; (
	input wire i_clock,
	input wire i_reset,
	input wire reg_idx_t i_rs1,
	input wire reg_idx_t i_rs2,
	output word_t o_rs1_data,
	output word_t o_rs2_data,
	input wire i_wr_en,
	input wire reg_idx_t i_wr_idx,
	input wire word_t i_wr_data
);
	word_t regs [32];

	// x0 is hardwired
	assign o_rs1_data = (i_rs1 == 5'd0) ? 32'd0 : regs[i_rs1];
	assign o_rs2_data = (i_rs2 == 5'd0) ? 32'd0 : regs[i_rs2];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= 32'd0;
			end
			regs[2] <= RESET_SP;
		end else if (i_wr_en && i_wr_idx != 5'd0) begin
			regs[i_wr_idx] <= i_wr_data;
		end
	end
endmodule

`default_nettype wire

/* src/rv_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_top import rv_pkg::*; (
	input wire i_clock,
	input wire i_reset,
	output logic o_rw,
	output logic o_request,
	input wire i_ready,
	output word_t o_address,
	input wire word_t i_data,
	output word_t o_data,
	output word_t o_pc,
	output logic o_error
);
	mem_req_if mem ();

	op_class_t op_class;
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	word_t imm;
	alu_op_t dec_alu_op;
	alu_op_t alu_op;
	logic [2:0] funct3;
	logic alu_use_imm;
	word_t alu_a;
	word_t alu_b;
	word_t alu_result;
	logic branch_taken;
	word_t instruction;
	logic wr_en;
	reg_idx_t wr_idx;
	word_t wr_data;
	word_t rs1_data;
	word_t rs2_data;

	rv_control i_control (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_class(op_class),
		.i_rd(rd),
		.i_imm(imm),
		.i_alu_op(dec_alu_op),
		.i_funct3(funct3),
		.i_alu_use_imm(alu_use_imm),
		.i_alu_result(alu_result),
		.i_branch_taken(branch_taken),
		.o_alu_op(alu_op),
		.o_alu_a(alu_a),
		.o_alu_b(alu_b),
		.o_instruction(instruction),
		.o_wr_en(wr_en),
		.o_wr_idx(wr_idx),
		.o_wr_data(wr_data),
		.i_rs1_data(rs1_data),
		.i_rs2_data(rs2_data),
		.mem(mem.ctrl),
		.o_pc(o_pc),
		.o_error(o_error)
	);

	rv_regfile i_regfile (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_rs1(rs1),
		.i_rs2(rs2),
		.o_rs1_data(rs1_data),
		.o_rs2_data(rs2_data),
		.i_wr_en(wr_en),
		.i_wr_idx(wr_idx),
		.i_wr_data(wr_data)
	);

	rv_decode i_decode (
		.i_instruction(instruction),
		.o_class(op_class),
		.o_rd(rd),
		.o_rs1(rs1),
		.o_rs2(rs2),
		.o_imm(imm),
		.o_alu_op(dec_alu_op),
		.o_funct3(funct3),
		.o_alu_use_imm(alu_use_imm)
	);

	rv_alu i_alu (
		.i_op(alu_op),
		.i_a(alu_a),
		.i_b(alu_b),
		.i_funct3(funct3),
		.o_result(alu_result),
		.o_branch_taken(branch_taken)
	);

	rv_mem_port i_mem_port (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.mem(mem.port),
		.o_rw(o_rw),
		.o_request(o_request),
		.o_address(o_address),
		.i_data(i_data),
		.o_data(o_data),
		.i_ready(i_ready)
	);
endmodule

`default_nettype wire
